// ==== Makefile ====
TOOL     = verilator
FLAGS    = --timing --assert --timescale 1ns/1ps
TOP      = io_tb
FILELIST = all.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(BIN): $(FILELIST)
	$(TOOL) --binary -j 0 $(FLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# The run passes only when the pass message shows up in the output
sim: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf $(OBJ_DIR)

// ==== all.f ====
logic/io_pkg.sv
logic/io_timer.sv
logic/io_port.sv
logic/io_irq.sv
logic/io_apb_regs.sv
logic/io_top.sv
bench/io_assert.sv
bench/io_tb.sv

// ==== bench/io_assert.sv ====
`timescale 1ns/1ps

module io_assert #(
	parameter int PORT_W = io_pkg::PORT_W_DEF
) (
	input logic              clk,
	input logic              rst,
	input logic              psel_i,
	input logic              penable_i,
	input logic              pwrite_i,
	input logic [4:0]        idx_i,
	input logic [31:0]       pwdata_i,
	input logic              irq_return_i,
	input logic              irq_i,
	input logic [3:0]        irq_status_i,
	input logic [PORT_W-1:0] gpio_oe_i,
	input logic [8:0]        strobes_i
);
	import io_pkg::*;

	int error_count = 0;
	logic wr_access;
	logic strobed_idx;
	logic en_write;
	logic dir_write;

	assign wr_access = psel_i && penable_i && pwrite_i;
	assign strobed_idx = idx_i inside {REG_T0_COUNT, REG_T1_COUNT, REG_T0_TOP, REG_T1_TOP,
		REG_T0_PRE, REG_T1_PRE, REG_PORT_DIR, REG_PORT_DAT, REG_IRQ};
	assign en_write = wr_access && (idx_i == REG_IRQ) && pwdata_i[4] && pwdata_i[3];
	assign dir_write = wr_access && (idx_i == REG_PORT_DIR);

	// The enable is set only by a return or by a control write
	irq_needs_enable: assert property (@(posedge clk) disable iff (rst)
		$rose(irq_i) |-> $past(irq_status_i[3]) || $past(irq_return_i) || $past(en_write))
		else begin
			$error("irq_o rose without the interrupt enable being set");
			error_count++;
		end

	oe_follows_dir: assert property (@(posedge clk) disable iff (rst)
		gpio_oe_i == ($past(dir_write) ? $past(pwdata_i[PORT_W-1:0]) : $past(gpio_oe_i)))
		else begin
			$error("gpio_oe_o does not follow the direction register writes");
			error_count++;
		end

	// Each APB write selects a single register
	one_strobe: assert property (@(posedge clk) disable iff (rst)
		$onehot0(strobes_i) && ((strobes_i != '0) == (wr_access && strobed_idx)))
		else begin
			$error("write strobes do not match the APB write access");
			error_count++;
		end

endmodule

bind io_top io_assert #(.PORT_W(PORT_W)) u_assert (
	.clk(clk), .rst(rst), .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
	.idx_i(paddr_i[6:2]), .pwdata_i(pwdata_i), .irq_return_i(irq_return_i),
	.irq_i(irq_o), .irq_status_i(irq_status), .gpio_oe_i(gpio_oe_o),
	.strobes_i({t0_wr_count, t0_wr_top, t0_wr_pre, t1_wr_count, t1_wr_top,
		t1_wr_pre, wr_dir, wr_dat, wr_irq})
);

// ==== bench/io_tb.sv ====
`timescale 1ns/1ps

module io_tb;
	import io_pkg::*;

	localparam int CLK_PERIOD = 4;
	// Cycle budget of each test, counting about four cycles per APB transfer
	localparam int RESET_CYCLES = 10;
	localparam int T1_CYCLES = 55;
	localparam int T2_CYCLES = 50;
	localparam int T3_CYCLES = 90;
	localparam int T4_CYCLES = 80;
	localparam int T5_CYCLES = 70;
	localparam int TEST_CYCLES = RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES
		+ T4_CYCLES + T5_CYCLES;
	localparam int WATCHDOG_NS = 2 * TEST_CYCLES * CLK_PERIOD;
	localparam logic [31:0] PRE_MASK = (32'd1 << PRE_W_DEF) - 32'd1;

	logic clk;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	logic [7:0] paddr;
	logic [31:0] pwdata;
	logic [7:0] gpio_in;
	logic irq_return;
	logic irq_taken;
	logic [31:0] prdata;
	logic [7:0] gpio_out;
	logic [7:0] gpio_oe;
	logic irq;
	int pass_count;
	int fail_count;
	int assert_fails;
	integer seed;

	io_top u_dut (
		.clk(clk), .rst(rst), .psel_i(psel), .penable_i(penable), .pwrite_i(pwrite),
		.paddr_i(paddr), .pwdata_i(pwdata), .gpio_in_i(gpio_in),
		.irq_return_i(irq_return), .irq_taken_i(irq_taken), .prdata_o(prdata),
		.gpio_out_o(gpio_out), .gpio_oe_o(gpio_oe), .irq_o(irq)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("TEST FAILED");
		$finish;
	end

	task automatic check(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
			fail_count++;
		end else begin
			pass_count++;
		end
	endtask

	task automatic apb_write(input logic [4:0] idx, input logic [31:0] data);
		@(posedge clk);
		psel <= 1'b1; // Setup cycle
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= {1'b0, idx, 2'b00};
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
	endtask

	task automatic apb_read(input logic [4:0] idx, output logic [31:0] data);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= {1'b0, idx, 2'b00};
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		data = prdata; // Middle of the access cycle
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	// Outputs are registered, so the falling edge sees them settled
	task automatic sample_point();
		@(negedge clk);
	endtask

	task automatic report_test(input string name, input int fails_before);
		$display("test %s finished with %0d mismatches", name, fail_count - fails_before);
	endtask

	task automatic reset_values();
		int fails;
		logic [31:0] rd;
		fails = fail_count;
		apb_read(REG_T0_COUNT, rd);
		check("reset_t0_count", 32'd0, rd);
		apb_read(REG_T1_COUNT, rd);
		check("reset_t1_count", 32'd0, rd);
		apb_read(REG_T0_TOP, rd);
		check("reset_t0_top", 32'hFFFF_FFFF, rd);
		apb_read(REG_T1_TOP, rd);
		check("reset_t1_top", 32'hFFFF_FFFF, rd);
		apb_read(REG_T0_PRE, rd);
		check("reset_t0_pre", 32'(PRE_RESET), rd);
		apb_read(REG_T1_PRE, rd);
		check("reset_t1_pre", 32'(PRE_RESET), rd);
		apb_read(REG_PORT_DIR, rd);
		check("reset_dir", 32'd0, rd);
		apb_read(REG_PORT_DAT, rd);
		check("reset_dat", 32'(PORT_DAT_RESET), rd);
		apb_read(REG_IRQ, rd);
		check("reset_irq", 32'd0, rd);
		apb_read(REG_ID0, rd);
		check("reset_id0", ID0_WORD, rd);
		apb_read(REG_ID1, rd);
		check("reset_id1", ID1_WORD, rd);
		apb_read(5'd7, rd);
		check("reset_unmapped", UNMAPPED_WORD, rd);
		sample_point();
		check("reset_gpio_oe", 32'd0, 32'(gpio_oe));
		check("reset_gpio_out", 32'(PORT_DAT_RESET), 32'(gpio_out));
		check("reset_irq_o", 32'd0, 32'(irq));
		check("reset_prdata_idle", 32'd0, prdata);
		report_test("reset_values", fails);
	endtask

	task automatic write_readback();
		int fails;
		logic [31:0] vals [5];
		logic [31:0] rd;
		fails = fail_count;
		foreach (vals[i])
			vals[i] = $random(seed);
		apb_write(REG_SCRATCH, vals[0]);
		apb_write(REG_T0_TOP, vals[1]);
		apb_write(REG_T1_TOP, vals[2]);
		apb_write(REG_T0_PRE, vals[3]);
		apb_write(REG_T1_PRE, vals[4]);
		apb_read(REG_SCRATCH, rd);
		check("rw_scratch", vals[0], rd);
		apb_read(REG_T0_TOP, rd);
		check("rw_t0_top", vals[1], rd);
		apb_read(REG_T1_TOP, rd);
		check("rw_t1_top", vals[2], rd);
		apb_read(REG_T0_PRE, rd);
		check("rw_t0_pre", vals[3] & PRE_MASK, rd);
		apb_read(REG_T1_PRE, rd);
		check("rw_t1_pre", vals[4] & PRE_MASK, rd);
		report_test("write_readback", fails);
	endtask

	task automatic timer_wrap();
		int fails;
		logic [31:0] rd;
		fails = fail_count;
		apb_write(REG_T0_PRE, 32'd1);
		apb_write(REG_T0_TOP, 32'd3);
		apb_write(REG_T0_COUNT, 32'd0);
		apb_write(REG_ALT, 32'h4);
		repeat (40) @(posedge clk); // Wrap period is (1+1)*(3+1) cycles
		apb_read(REG_IRQ, rd);
		check("wrap_flag1_set", 32'd1, (rd >> 1) & 32'd1);
		apb_write(REG_ALT, 32'h0); // Stop new wraps from raising the flag
		apb_write(REG_IRQ, 32'h2);
		apb_read(REG_IRQ, rd);
		check("wrap_flag1_clear", 32'd0, (rd >> 1) & 32'd1);
		report_test("timer_wrap", fails);
	endtask

	task automatic port_io();
		int fails;
		logic [31:0] rd;
		logic [31:0] rnd;
		logic start_bit;
		logic changed;
		fails = fail_count;
		apb_write(REG_PORT_DIR, 32'hF0);
		apb_write(REG_PORT_DAT, 32'hA5);
		sample_point();
		check("port_oe", 32'hF0, 32'(gpio_oe));
		check("port_out", 32'hA5, 32'(gpio_out));
		rnd = $random(seed);
		@(posedge clk);
		gpio_in <= rnd[7:0];
		apb_read(REG_PORT_PIN, rd);
		check("port_pin", 32'(rnd[7:0]), rd);
		apb_write(REG_T1_PRE, 32'd0);
		apb_write(REG_T1_TOP, 32'd1);
		apb_write(REG_T1_COUNT, 32'd0);
		apb_write(REG_ALT, 32'h1);
		sample_point();
		start_bit = gpio_out[0];
		changed = 1'b0;
		for (int i = 0; i < 10 && !changed; i++) begin
			sample_point();
			if (gpio_out[0] !== start_bit)
				changed = 1'b1;
		end
		check("port_toggle", 32'd1, 32'(changed));
		apb_write(REG_ALT, 32'h9);
		repeat (2) sample_point();
		check("port_force_low", 32'd0, 32'(gpio_out[0]));
		apb_read(REG_PORT_DAT, rd);
		check("port_force_low_dat", 32'd0, rd & 32'd1);
		apb_write(REG_ALT, 32'h0);
		report_test("port", fails);
	endtask

	task automatic edge_irq();
		int fails;
		logic [31:0] rd;
		fails = fail_count;
		@(posedge clk);
		gpio_in <= 8'h00;
		apb_write(REG_IRQ, 32'h3); // Clear flags 0 and 1, flag 2 low
		apb_write(REG_ALT, 32'h2);
		@(posedge clk);
		gpio_in <= 8'h02;
		apb_read(REG_IRQ, rd);
		check("edge_flag0", 32'h1, rd);
		sample_point();
		check("edge_irq_low", 32'd0, 32'(irq));
		apb_write(REG_IRQ, 32'h18);
		sample_point();
		check("enable_irq_high", 32'd1, 32'(irq));
		@(posedge clk);
		irq_taken <= 1'b1;
		@(posedge clk);
		irq_taken <= 1'b0;
		sample_point();
		check("taken_irq_low", 32'd0, 32'(irq));
		@(posedge clk);
		irq_return <= 1'b1;
		@(posedge clk);
		irq_return <= 1'b0;
		sample_point();
		check("return_irq_high", 32'd1, 32'(irq));
		apb_write(REG_IRQ, 32'h1);
		sample_point();
		check("clear_irq_low", 32'd0, 32'(irq));
		apb_read(REG_IRQ, rd);
		check("clear_keeps_enable", 32'h8, rd);
		report_test("edge_irq", fails);
	endtask

	initial begin
		pass_count = 0;
		fail_count = 0;
		seed = 32'h1891;
		rst <= 1'b1;
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= 8'h00;
		pwdata <= 32'h0;
		gpio_in <= 8'h00;
		irq_return <= 1'b0;
		irq_taken <= 1'b0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		reset_values();
		write_readback();
		timer_wrap();
		port_io();
		edge_irq();
		assert_fails = u_dut.u_assert.error_count;
		$display("Checks: %0d matched, %0d mismatched, %0d assertion failures",
			pass_count, fail_count, assert_fails);
		if (fail_count == 0 && assert_fails == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// ==== logic/io_apb_regs.sv ====
`timescale 1ns/1ps

module io_apb_regs #(
	parameter int TIMER_W = io_pkg::TIMER_W_DEF,
	parameter int PRE_W = io_pkg::PRE_W_DEF,
	parameter int PORT_W = io_pkg::PORT_W_DEF
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               psel_i,
	input  logic               penable_i,
	input  logic               pwrite_i,
	input  logic [7:0]         paddr_i,
	input  logic [31:0]        pwdata_i,
	input  logic [TIMER_W-1:0] t0_count_i,
	input  logic [TIMER_W-1:0] t0_top_i,
	input  logic [PRE_W-1:0]   t0_pre_i,
	input  logic [TIMER_W-1:0] t1_count_i,
	input  logic [TIMER_W-1:0] t1_top_i,
	input  logic [PRE_W-1:0]   t1_pre_i,
	input  logic [PORT_W-1:0]  dir_i,
	input  logic [PORT_W-1:0]  dat_i,
	input  logic [PORT_W-1:0]  pin_i,
	input  logic [3:0]         irq_status_i,
	output logic [31:0]        prdata_o,
	output logic [31:0]        wdata_o,
	output logic               t0_wr_count_o,
	output logic               t0_wr_top_o,
	output logic               t0_wr_pre_o,
	output logic               t1_wr_count_o,
	output logic               t1_wr_top_o,
	output logic               t1_wr_pre_o,
	output logic               wr_dir_o,
	output logic               wr_dat_o,
	output logic               wr_irq_o,
	output logic               alt_toggle_o,
	output logic               alt_force_low_o,
	output logic               edge_en_o,
	output logic               tmr_irq_en_o
);
	import io_pkg::*;

	reg_idx_e idx;
	logic access;
	logic wr_en;
	logic [3:0] alt_q;
	logic [31:0] scratch_q;
	logic [31:0] rd_word;

	assign idx = reg_idx_e'(paddr_i[6:2]);
	assign access = psel_i && penable_i; // Second cycle of the transfer
	assign wr_en = access && pwrite_i;
	assign wdata_o = pwdata_i;

	assign t0_wr_count_o = wr_en && (idx == REG_T0_COUNT);
	assign t1_wr_count_o = wr_en && (idx == REG_T1_COUNT);
	assign t0_wr_top_o = wr_en && (idx == REG_T0_TOP);
	assign t1_wr_top_o = wr_en && (idx == REG_T1_TOP);
	assign t0_wr_pre_o = wr_en && (idx == REG_T0_PRE);
	assign t1_wr_pre_o = wr_en && (idx == REG_T1_PRE);
	assign wr_dir_o = wr_en && (idx == REG_PORT_DIR);
	assign wr_dat_o = wr_en && (idx == REG_PORT_DAT);
	assign wr_irq_o = wr_en && (idx == REG_IRQ);

	always_ff @(posedge clk) begin
		if (rst) begin
			alt_q <= '0;
			scratch_q <= '0;
		end else if (wr_en) begin
			if (idx == REG_ALT)
				alt_q <= pwdata_i[3:0];
			if (idx == REG_SCRATCH)
				scratch_q <= pwdata_i;
		end
	end

	assign alt_toggle_o = alt_q[0];
	assign edge_en_o = alt_q[1];
	assign tmr_irq_en_o = alt_q[2];
	assign alt_force_low_o = alt_q[3];

	always_comb begin
		case (idx)
			REG_T0_COUNT: rd_word = 32'(t0_count_i);
			REG_T1_COUNT: rd_word = 32'(t1_count_i);
			REG_T0_TOP:   rd_word = 32'(t0_top_i);
			REG_T1_TOP:   rd_word = 32'(t1_top_i);
			REG_T0_PRE:   rd_word = 32'(t0_pre_i);
			REG_T1_PRE:   rd_word = 32'(t1_pre_i);
			REG_PORT_DIR: rd_word = 32'(dir_i);
			REG_PORT_DAT: rd_word = 32'(dat_i);
			REG_PORT_PIN: rd_word = 32'(pin_i);
			REG_ALT:      rd_word = 32'(alt_q);
			REG_IRQ:      rd_word = 32'(irq_status_i);
			REG_SCRATCH:  rd_word = scratch_q;
			REG_ID0:      rd_word = ID0_WORD;
			REG_ID1:      rd_word = ID1_WORD;
			default:      rd_word = UNMAPPED_WORD;
		endcase
	end

	assign prdata_o = access ? rd_word : '0;

endmodule

// ==== logic/io_irq.sv ====
`timescale 1ns/1ps

module io_irq (
	input  logic       clk,
	input  logic       rst,
	input  logic       wr_ctrl_i,
	input  logic [4:0] wdata_i,
	input  logic       tmr_irq_en_i,
	input  logic       t0_wrap_i,
	input  logic       pin_edge_i,
	input  logic       irq_return_i,
	input  logic       irq_taken_i,
	output logic [3:0] status_o,
	output logic       irq_o
);

	logic flag0_q;
	logic flag1_q;
	logic flag2_q;
	logic en_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			flag0_q <= 1'b0;
			flag1_q <= 1'b0;
			flag2_q <= 1'b0;
			en_q <= 1'b0;
		end else begin
			if (pin_edge_i)
				flag0_q <= 1'b1;
			if (t0_wrap_i && tmr_irq_en_i)
				flag1_q <= 1'b1;

			// Later assignments take priority
			if (irq_return_i)
				en_q <= 1'b1;
			if (irq_taken_i)
				en_q <= 1'b0;

			if (wr_ctrl_i) begin
				if (wdata_i[0])
					flag0_q <= 1'b0;
				if (wdata_i[1])
					flag1_q <= 1'b0;
				flag2_q <= wdata_i[2]; // Software interrupt
				if (wdata_i[4])
					en_q <= wdata_i[3];
			end
		end
	end

	assign status_o = {en_q, flag2_q, flag1_q, flag0_q};
	assign irq_o = en_q && (flag0_q || flag1_q || flag2_q);

endmodule

// ==== logic/io_pkg.sv ====
package io_pkg;

	// Word index of each register, taken from paddr[6:2]
	typedef enum logic [4:0] {
		REG_T0_COUNT = 5'd0,
		REG_T1_COUNT = 5'd1,
		REG_T0_TOP   = 5'd2,
		REG_T1_TOP   = 5'd3,
		REG_T0_PRE   = 5'd4,
		REG_T1_PRE   = 5'd5,
		REG_PORT_DIR = 5'd11,
		REG_PORT_DAT = 5'd12,
		REG_PORT_PIN = 5'd13,
		REG_ALT      = 5'd14,
		REG_IRQ      = 5'd15,
		REG_SCRATCH  = 5'd17,
		REG_ID0      = 5'd18,
		REG_ID1      = 5'd19
	} reg_idx_e;

	localparam int TIMER_W_DEF = 32;
	localparam int PRE_W_DEF = 17;
	localparam int PORT_W_DEF = 8;

	// Prescaler value after reset, so a timer ticks every 101 cycles
	localparam int PRE_RESET = 100;

	localparam logic [7:0] PORT_DAT_RESET = 8'h55;

	// "Chir" and "p!" in little-endian byte order
	localparam logic [31:0] ID0_WORD = 32'h72696843;
	localparam logic [31:0] ID1_WORD = 32'h00002170;

	localparam logic [31:0] UNMAPPED_WORD = 32'hFFFF_FFFF;

endpackage

// ==== logic/io_port.sv ====
`timescale 1ns/1ps

module io_port #(
	parameter int PORT_W = io_pkg::PORT_W_DEF
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              wr_dir_i,
	input  logic              wr_dat_i,
	input  logic [PORT_W-1:0] wdata_i,
	input  logic              alt_toggle_i,
	input  logic              alt_force_low_i,
	input  logic              edge_en_i,
	input  logic              t1_wrap_i,
	input  logic [PORT_W-1:0] gpio_in_i,
	output logic [PORT_W-1:0] dir_o,
	output logic [PORT_W-1:0] dat_o,
	output logic [PORT_W-1:0] gpio_out_o,
	output logic [PORT_W-1:0] gpio_oe_o,
	output logic              pin_edge_o
);
	import io_pkg::*;

	logic [PORT_W-1:0] dir_q;
	logic [PORT_W-1:0] dat_q;
	logic pin1_q; // Previous sample of input pin 1

	assign pin_edge_o = edge_en_i && gpio_in_i[1] && !pin1_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			dir_q <= '0;
			dat_q <= PORT_W'(PORT_DAT_RESET);
			pin1_q <= 1'b0;
		end else begin
			pin1_q <= edge_en_i ? gpio_in_i[1] : 1'b0;

			if (wr_dir_i)
				dir_q <= wdata_i;

			if (wr_dat_i) begin
				dat_q <= wdata_i;
			end else if (alt_force_low_i) begin
				dat_q[0] <= 1'b0;
			end else if (alt_toggle_i && t1_wrap_i) begin
				// Timer 1 drives a square wave out on bit 0
				dat_q[0] <= ~dat_q[0];
			end
		end
	end

	assign dir_o = dir_q;
	assign dat_o = dat_q;
	assign gpio_out_o = dat_q;
	assign gpio_oe_o = dir_q; // A set direction bit makes the pin an output

endmodule

// ==== logic/io_timer.sv ====
`timescale 1ns/1ps

module io_timer #(
	parameter int TIMER_W = io_pkg::TIMER_W_DEF,
	parameter int PRE_W = io_pkg::PRE_W_DEF
) (
	input  logic               clk,
	input  logic               rst,
	input  logic               wr_count_i,
	input  logic               wr_top_i,
	input  logic               wr_pre_i,
	input  logic [TIMER_W-1:0] wdata_i,
	output logic [TIMER_W-1:0] count_o,
	output logic [TIMER_W-1:0] top_o,
	output logic [PRE_W-1:0]   pre_o,
	output logic               wrap_o
);
	import io_pkg::*;

	logic [TIMER_W-1:0] count_q;
	logic [TIMER_W-1:0] top_q;
	logic [PRE_W-1:0] pre_q;
	logic [PRE_W-1:0] pre_cnt_q;
	logic tick;
	logic at_top;

	assign tick = (pre_cnt_q == pre_q); // Prescaler period complete
	assign at_top = (count_q == top_q);
	assign wrap_o = tick && at_top;

	always_ff @(posedge clk) begin
		if (rst) begin
			count_q <= '0;
			top_q <= '1;
			pre_q <= PRE_W'(PRE_RESET);
			pre_cnt_q <= '0;
		end else begin
			// A new prescaler value starts a fresh period
			if (tick || wr_pre_i)
				pre_cnt_q <= '0;
			else
				pre_cnt_q <= pre_cnt_q + 1'b1;

			// A bus write of the count beats the tick but leaves the prescale phase alone
			if (wr_count_i)
				count_q <= wdata_i;
			else if (tick)
				count_q <= at_top ? '0 : count_q + 1'b1;

			if (wr_top_i)
				top_q <= wdata_i;
			if (wr_pre_i)
				pre_q <= wdata_i[PRE_W-1:0];
		end
	end

	assign count_o = count_q;
	assign top_o = top_q;
	assign pre_o = pre_q;

endmodule

// ==== logic/io_top.sv ====
`timescale 1ns/1ps

module io_top #(
	parameter int TIMER_W = io_pkg::TIMER_W_DEF,
	parameter int PRE_W = io_pkg::PRE_W_DEF,
	parameter int PORT_W = io_pkg::PORT_W_DEF
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              psel_i,
	input  logic              penable_i,
	input  logic              pwrite_i,
	input  logic [7:0]        paddr_i,
	input  logic [31:0]       pwdata_i,
	input  logic [PORT_W-1:0] gpio_in_i,
	input  logic              irq_return_i,
	input  logic              irq_taken_i,
	output logic [31:0]       prdata_o,
	output logic [PORT_W-1:0] gpio_out_o,
	output logic [PORT_W-1:0] gpio_oe_o,
	output logic              irq_o
);

	logic [31:0] wdata;
	logic t0_wr_count, t0_wr_top, t0_wr_pre;
	logic t1_wr_count, t1_wr_top, t1_wr_pre;
	logic wr_dir, wr_dat, wr_irq;
	logic alt_toggle, alt_force_low, edge_en, tmr_irq_en;
	logic [TIMER_W-1:0] t0_count, t0_top, t1_count, t1_top;
	logic [PRE_W-1:0] t0_pre, t1_pre;
	logic t0_wrap, t1_wrap;
	logic [PORT_W-1:0] dir, dat;
	logic pin_edge;
	logic [3:0] irq_status;

	io_apb_regs #(.TIMER_W(TIMER_W), .PRE_W(PRE_W), .PORT_W(PORT_W)) u_regs (
		.clk(clk), .rst(rst), .psel_i(psel_i), .penable_i(penable_i),
		.pwrite_i(pwrite_i), .paddr_i(paddr_i), .pwdata_i(pwdata_i),
		.t0_count_i(t0_count), .t0_top_i(t0_top), .t0_pre_i(t0_pre),
		.t1_count_i(t1_count), .t1_top_i(t1_top), .t1_pre_i(t1_pre),
		.dir_i(dir), .dat_i(dat), .pin_i(gpio_in_i), .irq_status_i(irq_status),
		.prdata_o(prdata_o), .wdata_o(wdata),
		.t0_wr_count_o(t0_wr_count), .t0_wr_top_o(t0_wr_top), .t0_wr_pre_o(t0_wr_pre),
		.t1_wr_count_o(t1_wr_count), .t1_wr_top_o(t1_wr_top), .t1_wr_pre_o(t1_wr_pre),
		.wr_dir_o(wr_dir), .wr_dat_o(wr_dat), .wr_irq_o(wr_irq),
		.alt_toggle_o(alt_toggle), .alt_force_low_o(alt_force_low),
		.edge_en_o(edge_en), .tmr_irq_en_o(tmr_irq_en)
	);

	io_timer #(.TIMER_W(TIMER_W), .PRE_W(PRE_W)) u_timer0 (
		.clk(clk), .rst(rst), .wr_count_i(t0_wr_count), .wr_top_i(t0_wr_top),
		.wr_pre_i(t0_wr_pre), .wdata_i(wdata[TIMER_W-1:0]),
		.count_o(t0_count), .top_o(t0_top), .pre_o(t0_pre), .wrap_o(t0_wrap)
	);

	io_timer #(.TIMER_W(TIMER_W), .PRE_W(PRE_W)) u_timer1 (
		.clk(clk), .rst(rst), .wr_count_i(t1_wr_count), .wr_top_i(t1_wr_top),
		.wr_pre_i(t1_wr_pre), .wdata_i(wdata[TIMER_W-1:0]),
		.count_o(t1_count), .top_o(t1_top), .pre_o(t1_pre), .wrap_o(t1_wrap)
	);

	io_port #(.PORT_W(PORT_W)) u_port (
		.clk(clk), .rst(rst), .wr_dir_i(wr_dir), .wr_dat_i(wr_dat),
		.wdata_i(wdata[PORT_W-1:0]), .alt_toggle_i(alt_toggle),
		.alt_force_low_i(alt_force_low), .edge_en_i(edge_en), .t1_wrap_i(t1_wrap),
		.gpio_in_i(gpio_in_i), .dir_o(dir), .dat_o(dat),
		.gpio_out_o(gpio_out_o), .gpio_oe_o(gpio_oe_o), .pin_edge_o(pin_edge)
	);

	io_irq u_irq (
		.clk(clk), .rst(rst), .wr_ctrl_i(wr_irq), .wdata_i(wdata[4:0]),
		.tmr_irq_en_i(tmr_irq_en), .t0_wrap_i(t0_wrap), .pin_edge_i(pin_edge),
		.irq_return_i(irq_return_i), .irq_taken_i(irq_taken_i),
		.status_o(irq_status), .irq_o(irq_o)
	);

endmodule
